/* cls_driver/cls_boot_timer.sv */
`timescale 1ns/1ps

module cls_boot_timer #(
    parameter int BOOT_TICKS = 20
) (
    input  logic i_ext_spi_clk_x,
    input  logic i_srst,
    input  logic i_spi_ce_4x,
    output logic o_boot_done
);

    // the count never goes past BOOT_TICKS-1, so this width is always enough
    localparam int CNT_W = (BOOT_TICKS > 1) ? $clog2(BOOT_TICKS) : 1;
    localparam logic [CNT_W-1:0] LAST_TICK = CNT_W'(BOOT_TICKS - 1);

    // enable ticks seen since reset was released
    logic [CNT_W-1:0] tick_cnt;

    // --------------------
    // saturating tick counter
    // --------------------

    // the display controller boots on its own and gives no ready signal,
    // so the driver simply waits out a fixed number of enable ticks
    always_ff @(posedge i_ext_spi_clk_x) begin
        if (i_srst) begin
            tick_cnt <= '0;
        end else if (i_spi_ce_4x && (tick_cnt != LAST_TICK)) begin
            tick_cnt <= tick_cnt + 1'b1;
        end
    end

    // stays high once reached since the counter stops at the last tick
    assign o_boot_done = (tick_cnt == LAST_TICK);

endmodule

/* cls_driver/cls_byte_streamer.sv */
`timescale 1ns/1ps

module cls_byte_streamer #(
    parameter type PAYLOAD_T = cls_proto_pkg::t_cls_text_line
) (
    input  logic                          i_ext_spi_clk_x,
    input  logic                          i_srst,
    input  logic                          i_spi_ce_4x,
    input  logic                          i_start,
    input  PAYLOAD_T                      i_payload,
    input  cls_proto_pkg::t_cls_len       i_len,
    input  spi_link_pkg::t_spi_tx_status  i_status,
    output spi_link_pkg::t_spi_tx_req     o_req,
    output logic                          o_done
);

    import cls_proto_pkg::*;

    localparam int N_BYTES = $bits(PAYLOAD_T) / 8;
    localparam int IDX_W   = (N_BYTES > 1) ? $clog2(N_BYTES) : 1;

    PAYLOAD_T payload_q;
    // length of the whole payload, reported to the master as tx_len
    t_cls_len len_q;
    // bytes still to be enqueued, zero when the streamer is idle
    t_cls_len remain_q;

    logic             active;
    logic             accept;
    logic             last_byte;
    logic [IDX_W-1:0] byte_idx;
    t_cls_byte        cur_byte;

    assign active    = (remain_q != '0);
    // the FIFO takes a byte whenever it is ready, which is the only back-pressure
    assign accept    = active && i_status.tx_ready;
    assign last_byte = (remain_q == 5'd1);

    // the payload is right aligned, so the next byte sits at position remain-1
    // counted from the low end
    assign byte_idx = IDX_W'(remain_q - 5'd1);
    assign cur_byte = payload_q[8*byte_idx +: 8];

    // --------------------
    // position and length
    // --------------------
    always_ff @(posedge i_ext_spi_clk_x) begin
        if (i_srst) begin
            remain_q <= '0;
            len_q    <= '0;
        end else if (i_spi_ce_4x) begin
            if (i_start) begin
                remain_q <= i_len;
                len_q    <= i_len;
            end else if (accept) begin
                remain_q <= remain_q - 5'd1;
            end
        end
    end

    // payload copy so the builder is free again once the phase has started
    always_ff @(posedge i_ext_spi_clk_x) begin
        if (i_spi_ce_4x && i_start) begin
            payload_q <= i_payload;
        end
    end

    // --------------------
    // request to the master
    // --------------------

    // the transfer is started together with the last byte of the phase
    always_comb begin
        o_req.tx_data    = active ? cur_byte : 8'h00;
        o_req.tx_enqueue = accept;
        o_req.go_stand   = accept && last_byte;
        o_req.tx_len     = len_q;
    end

    assign o_done = accept && last_byte;

endmodule

/* cls_driver/cls_driver_fsm.sv */
`timescale 1ns/1ps

module cls_driver_fsm (
    input  logic                         i_ext_spi_clk_x,
    input  logic                         i_srst,
    input  logic                         i_spi_ce_4x,
    input  logic                         i_boot_done,
    input  logic                         i_cmd_any,
    input  cls_proto_pkg::t_cls_len      i_dat_len,
    input  logic                         i_cmd_done,
    input  logic                         i_dat_done,
    input  spi_link_pkg::t_spi_tx_req    i_cmd_req,
    input  spi_link_pkg::t_spi_tx_req    i_dat_req,
    input  spi_link_pkg::t_spi_tx_status i_status,
    output logic                         o_command_ready,
    output logic                         o_load,
    output logic                         o_start_cmd,
    output logic                         o_start_dat,
    output spi_link_pkg::t_spi_tx_req    o_spi_req
);

    typedef enum logic [2:0] {
        ST_BOOT,
        ST_IDLE,
        ST_LOAD,
        ST_CMD_RUN,
        ST_CMD_WAIT,
        ST_DAT_RUN,
        ST_DAT_WAIT
    } t_drv_state;

    t_drv_state state_q;
    t_drv_state state_nx;

    // --------------------
    // state register
    // --------------------

    // one step per enable tick, nothing moves in between
    always_ff @(posedge i_ext_spi_clk_x) begin
        if (i_srst) begin
            state_q <= ST_BOOT;
        end else if (i_spi_ce_4x) begin
            state_q <= state_nx;
        end
    end

    // --------------------
    // next state
    // --------------------
    always_comb begin
        state_nx = state_q;
        case (state_q)
            ST_BOOT: begin
                // hold off until the display controller has had time to boot
                if (i_boot_done) begin
                    state_nx = ST_IDLE;
                end
            end
            ST_IDLE: begin
                if (i_cmd_any) begin
                    state_nx = ST_LOAD;
                end
            end
            // the message is registered now and the command streamer takes it
            ST_LOAD: state_nx = ST_CMD_RUN;
            ST_CMD_RUN: begin
                if (i_cmd_done) begin
                    state_nx = ST_CMD_WAIT;
                end
            end
            ST_CMD_WAIT: begin
                // a clear command has no text, so it ends here
                if (i_status.spi_idle) begin
                    state_nx = (i_dat_len != '0) ? ST_DAT_RUN : ST_IDLE;
                end
            end
            ST_DAT_RUN: begin
                if (i_dat_done) begin
                    state_nx = ST_DAT_WAIT;
                end
            end
            ST_DAT_WAIT: begin
                if (i_status.spi_idle) begin
                    state_nx = ST_IDLE;
                end
            end
            default: state_nx = ST_BOOT;
        endcase
    end

    // --------------------
    // outputs
    // --------------------
    assign o_command_ready = (state_q == ST_IDLE);
    // builder and streamers only act on enable ticks, so level pulses are enough
    assign o_load          = (state_q == ST_IDLE) && i_cmd_any;
    assign o_start_cmd     = (state_q == ST_LOAD);
    // the data streamer is started by the same idle that ends the command phase
    assign o_start_dat     = (state_q == ST_CMD_WAIT) && i_status.spi_idle &&
                             (i_dat_len != '0);

    // only the streamer of the running phase reaches the master
    always_comb begin
        case (state_q)
            ST_CMD_RUN: o_spi_req = i_cmd_req;
            ST_DAT_RUN: o_spi_req = i_dat_req;
            default:    o_spi_req = '0;
        endcase
    end

endmodule

/* cls_driver/cls_message_builder.sv */
`timescale 1ns/1ps

module cls_message_builder (
    input  logic                          i_ext_spi_clk_x,
    input  logic                          i_srst,
    input  logic                          i_spi_ce_4x,
    input  logic                          i_load,
    input  logic                          i_cmd_clear,
    input  logic                          i_cmd_line1,
    input  cls_proto_pkg::t_cls_text_line i_line1,
    input  cls_proto_pkg::t_cls_text_line i_line2,
    output cls_proto_pkg::t_cls_message   o_msg
);

    import cls_proto_pkg::*;

    t_cls_cmd_seq   cmd_seq_q;
    t_cls_len       cmd_len_q;
    t_cls_text_line text_q;
    t_cls_len       text_len_q;

    // row digit of the cursor sequence, '0' for the top line and '1' for the bottom
    t_cls_byte row_digit;

    // anything that is neither clear nor line 1 is taken as a line 2 write
    assign row_digit = i_cmd_line1 ? C_ASCII_ZERO : (C_ASCII_ZERO + 8'd1);

    // --------------------
    // payload lengths
    // --------------------

    // a zero text length tells the FSM to skip the data phase
    always_ff @(posedge i_ext_spi_clk_x) begin
        if (i_srst) begin
            cmd_len_q  <= '0;
            text_len_q <= '0;
        end else if (i_spi_ce_4x && i_load) begin
            if (i_cmd_clear) begin
                cmd_len_q  <= C_CLEAR_LEN;
                text_len_q <= '0;
            end else begin
                cmd_len_q  <= C_CURSOR_LEN;
                text_len_q <= C_LINE_LEN;
            end
        end
    end

    // --------------------
    // payload bytes
    // --------------------

    // clear beats line 1 and line 1 beats line 2,
    // and the text is captured in the same cycle the command is taken
    always_ff @(posedge i_ext_spi_clk_x) begin
        if (i_spi_ce_4x && i_load) begin
            if (i_cmd_clear) begin
                // ESC [ 0 j in the low four bytes
                cmd_seq_q <= {24'h000000, C_ASCII_ESC, C_ASCII_BRACKET,
                              C_ASCII_ZERO, C_ASCII_CLEAR_CMD};
                text_q    <= '0;
            end else begin
                // ESC [ row ; 0 0 H puts the cursor at the start of the line
                cmd_seq_q <= {C_ASCII_ESC, C_ASCII_BRACKET, row_digit, C_ASCII_SEMICOLON,
                              C_ASCII_ZERO, C_ASCII_ZERO, C_ASCII_CURSOR_CMD};
                text_q    <= i_cmd_line1 ? i_line1 : i_line2;
            end
        end
    end

    assign o_msg = '{cmd_seq: cmd_seq_q, cmd_len: cmd_len_q,
                     text: text_q, text_len: text_len_q};

endmodule

/* common/cls_proto_pkg.sv */
package cls_proto_pkg;

    // --------------------
    // display payload types
    // --------------------

    // one ASCII character as it travels to the display
    typedef logic [7:0] t_cls_byte;

    // a full display line of 16 characters, first character in the top byte
    typedef logic [16*8-1:0] t_cls_text_line;

    // escape sequence buffer, right aligned so short sequences sit in the low bytes
    typedef logic [7*8-1:0] t_cls_cmd_seq;

    // byte count of one payload, 0 up to a full line of 16
    typedef logic [4:0] t_cls_len;

    // everything the two streamers need for one display command
    typedef struct packed {
        t_cls_cmd_seq   cmd_seq;
        t_cls_len       cmd_len;
        t_cls_text_line text;
        t_cls_len       text_len;
    } t_cls_message;

    // --------------------
    // ANSI escape characters
    // --------------------
    localparam t_cls_byte C_ASCII_ESC        = 8'h1B;
    localparam t_cls_byte C_ASCII_BRACKET    = 8'h5B;
    localparam t_cls_byte C_ASCII_ZERO       = 8'h30;
    localparam t_cls_byte C_ASCII_SEMICOLON  = 8'h3B;
    // ESC [ 0 j erases the whole display
    localparam t_cls_byte C_ASCII_CLEAR_CMD  = 8'h6A;
    // ESC [ row ; col H moves the cursor
    localparam t_cls_byte C_ASCII_CURSOR_CMD = 8'h48;

    // byte counts of the sequences above and of one text line
    localparam t_cls_len C_CLEAR_LEN  = 5'd4;
    localparam t_cls_len C_CURSOR_LEN = 5'd7;
    localparam t_cls_len C_LINE_LEN   = 5'd16;

endpackage

/* common/spi_link_pkg.sv */
package spi_link_pkg;

    // --------------------
    // link to the SPI master
    // --------------------

    // request side, sampled by the master on enabled cycles only
    typedef struct packed {
        // byte pushed into the transmit FIFO
        logic [7:0] tx_data;
        // push strobe, one byte per enabled cycle
        logic       tx_enqueue;
        // starts the transfer of everything queued so far
        logic       go_stand;
        // number of bytes the transfer will shift out
        logic [4:0] tx_len;
    } t_spi_tx_req;

    // status side, returned by the master
    typedef struct packed {
        // transmit FIFO can take a byte this cycle
        logic tx_ready;
        // no transfer in progress
        logic spi_idle;
    } t_spi_tx_status;

endpackage

/* design/cls_display_top.sv */
`timescale 1ns/1ps

module cls_display_top #(
    parameter int FCLK_CE  = 2500000,
    parameter int FAST_SIM = 0
) (
    input  logic                         i_ext_spi_clk_x,
    input  logic                         i_srst,
    input  logic                         i_spi_ce_4x,
    input  logic                         i_cmd_clear,
    input  logic                         i_cmd_line1,
    input  logic                         i_cmd_line2,
    input  cls_proto_pkg::t_cls_text_line i_line1,
    input  cls_proto_pkg::t_cls_text_line i_line2,
    input  spi_link_pkg::t_spi_tx_status i_spi_status,
    output logic                         o_command_ready,
    output spi_link_pkg::t_spi_tx_req    o_spi_req
);

    import cls_proto_pkg::*;
    import spi_link_pkg::*;

    // boot wait in enable ticks, 800 ms normally and 2 ms for quick simulation
    localparam int BOOT_TICKS = (FAST_SIM != 0) ? (FCLK_CE / 1000 * 2) :
                                                  (FCLK_CE / 1000 * 800);

    logic         boot_done;
    logic         cmd_any;
    logic         msg_load;
    logic         start_cmd;
    logic         start_dat;
    logic         cmd_done;
    logic         dat_done;
    t_cls_message msg;
    t_spi_tx_req  cmd_req;
    t_spi_tx_req  dat_req;

    assign cmd_any = i_cmd_clear || i_cmd_line1 || i_cmd_line2;

    // --------------------
    // driver blocks
    // --------------------
    cls_boot_timer #(
        .BOOT_TICKS(BOOT_TICKS)
    ) boot_timer_i (
        .i_ext_spi_clk_x(i_ext_spi_clk_x),
        .i_srst(i_srst),
        .i_spi_ce_4x(i_spi_ce_4x),
        .o_boot_done(boot_done)
    );

    // line 2 is implied when neither of the other commands is set
    cls_message_builder builder_i (
        .i_ext_spi_clk_x(i_ext_spi_clk_x),
        .i_srst(i_srst),
        .i_spi_ce_4x(i_spi_ce_4x),
        .i_load(msg_load),
        .i_cmd_clear(i_cmd_clear),
        .i_cmd_line1(i_cmd_line1),
        .i_line1(i_line1),
        .i_line2(i_line2),
        .o_msg(msg)
    );

    // escape sequence phase
    cls_byte_streamer #(
        .PAYLOAD_T(t_cls_cmd_seq)
    ) cmd_streamer_i (
        .i_ext_spi_clk_x(i_ext_spi_clk_x),
        .i_srst(i_srst),
        .i_spi_ce_4x(i_spi_ce_4x),
        .i_start(start_cmd),
        .i_payload(msg.cmd_seq),
        .i_len(msg.cmd_len),
        .i_status(i_spi_status),
        .o_req(cmd_req),
        .o_done(cmd_done)
    );

    // text phase
    cls_byte_streamer #(
        .PAYLOAD_T(t_cls_text_line)
    ) dat_streamer_i (
        .i_ext_spi_clk_x(i_ext_spi_clk_x),
        .i_srst(i_srst),
        .i_spi_ce_4x(i_spi_ce_4x),
        .i_start(start_dat),
        .i_payload(msg.text),
        .i_len(msg.text_len),
        .i_status(i_spi_status),
        .o_req(dat_req),
        .o_done(dat_done)
    );

    cls_driver_fsm fsm_i (
        .i_ext_spi_clk_x(i_ext_spi_clk_x),
        .i_srst(i_srst),
        .i_spi_ce_4x(i_spi_ce_4x),
        .i_boot_done(boot_done),
        .i_cmd_any(cmd_any),
        .i_dat_len(msg.text_len),
        .i_cmd_done(cmd_done),
        .i_dat_done(dat_done),
        .i_cmd_req(cmd_req),
        .i_dat_req(dat_req),
        .i_status(i_spi_status),
        .o_command_ready(o_command_ready),
        .o_load(msg_load),
        .o_start_cmd(start_cmd),
        .o_start_dat(start_dat),
        .o_spi_req(o_spi_req)
    );

endmodule

/* flist.f */
common/cls_proto_pkg.sv
common/spi_link_pkg.sv
cls_driver/cls_boot_timer.sv
cls_driver/cls_message_builder.sv
cls_driver/cls_byte_streamer.sv
cls_driver/cls_driver_fsm.sv
design/cls_display_top.sv
tb/tb_clock_gen.sv
tb/tb_cls_display.sv

/* run_sim.sh */
#!/bin/sh
# builds the cls display testbench with Verilator and runs it
# a $fatal in the testbench gives a nonzero exit status
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_cls_display \
    -f flist.f \
    -o tb_cls_display_sim

./obj_dir/tb_cls_display_sim

/* tb/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 8,
    parameter int RESET_CYCLES = 3
) (
    output logic o_clk,
    output logic o_srst
);

    logic clk_q  = 1'b0;
    logic srst_q = 1'b1;

    // free running clock, the first rising edge comes half a period in
    always #(PERIOD_NS / 2) clk_q = ~clk_q;

    // reset is seen high on the first RESET_CYCLES rising edges
    initial begin
        repeat (RESET_CYCLES) @(posedge clk_q);
        srst_q <= 1'b0;
    end

    assign o_clk  = clk_q;
    assign o_srst = srst_q;

endmodule

/* tb/tb_cls_display.sv */
`timescale 1ns/1ps

module tb_cls_display;

    import cls_proto_pkg::*;
    import spi_link_pkg::*;

    localparam int FCLK_CE_TB = 10000;
    // 2 ms at a 10 kHz enable rate is 20 enable ticks
    localparam int EXP_BOOT   = 20;
    localparam int BOOT_LIMIT = 500;
    localparam int CMD_LIMIT  = 2000;

    // one byte the master should see, with its go flag and transfer length
    typedef struct packed {
        logic [7:0] data;
        logic       go;
        logic [4:0] len;
    } t_exp_byte;

    logic           ext_spi_clk_x;
    logic           srst;
    logic           spi_ce_4x  = 1'b0;
    logic           cmd_clear  = 1'b0;
    logic           cmd_line1  = 1'b0;
    logic           cmd_line2  = 1'b0;
    t_cls_text_line line1      = '0;
    t_cls_text_line line2      = '0;
    t_spi_tx_status spi_status = '{tx_ready: 1'b0, spi_idle: 1'b1};
    logic           command_ready;
    t_spi_tx_req    spi_req;

    t_exp_byte exp_q[$];

    // command tracking, all updated on rising edges
    logic waiting_idle = 1'b0;
    logic cmd_busy     = 1'b0;
    logic ready_due    = 1'b0;
    int   phases_left  = 0;
    logic booted       = 1'b0;
    int   boot_ticks   = 0;
    // clock cycles left until the modelled transfer ends
    int   busy_left    = 0;

    tb_clock_gen #(
        .PERIOD_NS(8),
        .RESET_CYCLES(3)
    ) clock_gen_i (
        .o_clk(ext_spi_clk_x),
        .o_srst(srst)
    );

    cls_display_top #(
        .FCLK_CE(FCLK_CE_TB),
        .FAST_SIM(1)
    ) dut_i (
        .i_ext_spi_clk_x(ext_spi_clk_x),
        .i_srst(srst),
        .i_spi_ce_4x(spi_ce_4x),
        .i_cmd_clear(cmd_clear),
        .i_cmd_line1(cmd_line1),
        .i_cmd_line2(cmd_line2),
        .i_line1(line1),
        .i_line2(line2),
        .i_spi_status(spi_status),
        .o_command_ready(command_ready),
        .o_spi_req(spi_req)
    );

    // --------------------
    // error reporting
    // --------------------
    task automatic abort_run();
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic report_failure(input string why);
        $display("ERROR at %0d ns: %s", $time, why);
        abort_run();
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("MISMATCH at %0d ns: %s is %0h, expected %0h", $time, name, got, exp);
        abort_run();
    endtask

    // --------------------
    // SPI master model
    // --------------------

    // the enable strobe is high on about three cycles out of four
    always @(posedge ext_spi_clk_x) begin
        spi_ce_4x <= ($urandom_range(3, 0) != 0);
    end

    // the FIFO accepts at random, and a started transfer keeps the master busy for a while
    always @(posedge ext_spi_clk_x) begin : spi_master_model
        if (srst) begin
            spi_status.tx_ready <= 1'b0;
            spi_status.spi_idle <= 1'b1;
            busy_left           <= 0;
        end else begin
            spi_status.tx_ready <= ($urandom_range(9, 0) < 7);
            if (spi_ce_4x && spi_req.go_stand) begin
                spi_status.spi_idle <= 1'b0;
                busy_left           <= $urandom_range(12, 2);
            end else if (!spi_status.spi_idle) begin
                if (busy_left == 0) begin
                    spi_status.spi_idle <= 1'b1;
                end else begin
                    busy_left <= busy_left - 1;
                end
            end
        end
    end

    // --------------------
    // checks
    // --------------------

    // a byte may only go out when the FIFO has room
    tx_ready_respected: assert property (@(posedge ext_spi_clk_x) disable iff (srst)
        !(spi_req.tx_enqueue && !spi_status.tx_ready))
        else report_failure("tx_enqueue was high while tx_ready was low");

    // the transfer start always rides on the last byte of a phase
    go_with_byte: assert property (@(posedge ext_spi_clk_x) disable iff (srst)
        !(spi_req.go_stand && !spi_req.tx_enqueue))
        else report_failure("go_stand was high without a byte being enqueued");

    // nothing may move during boot, and ready comes after exactly EXP_BOOT enable ticks
    always @(posedge ext_spi_clk_x) begin : boot_check
        if (srst) begin
            boot_ticks <= 0;
            booted     <= 1'b0;
        end else if (!booted) begin
            assert (!spi_req.tx_enqueue && !spi_req.go_stand)
                else report_failure("SPI request was active during the boot wait");
            if (command_ready) begin
                assert (boot_ticks == EXP_BOOT)
                    else report_mismatch("boot enable ticks", boot_ticks, EXP_BOOT);
                booted <= 1'b1;
            end else if (spi_ce_4x) begin
                boot_ticks <= boot_ticks + 1;
            end
        end
    end

    // every enqueued byte is compared with the head of the expected queue
    always @(posedge ext_spi_clk_x) begin : byte_scoreboard
        t_exp_byte exp_b;
        if (!srst && spi_ce_4x && spi_req.tx_enqueue) begin
            assert (!waiting_idle)
                else report_failure("a byte was enqueued before spi_idle returned");
            assert (exp_q.size() != 0)
                else report_failure("a byte was enqueued while none was expected");
            if (exp_q.size() != 0) begin
                exp_b = exp_q.pop_front();
                assert (spi_req.tx_data == exp_b.data)
                    else report_mismatch("tx_data", 32'(spi_req.tx_data), 32'(exp_b.data));
                assert (spi_req.go_stand == exp_b.go)
                    else report_mismatch("go_stand", 32'(spi_req.go_stand), 32'(exp_b.go));
                assert (spi_req.tx_len == exp_b.len)
                    else report_mismatch("tx_len", 32'(spi_req.tx_len), 32'(exp_b.len));
            end
        end
    end

    // ready must stay low from acceptance until one enabled cycle after the final idle
    always @(posedge ext_spi_clk_x) begin : command_tracker
        if (srst) begin
            waiting_idle <= 1'b0;
            cmd_busy     <= 1'b0;
            ready_due    <= 1'b0;
            phases_left  <= 0;
        end else begin
            if (cmd_busy) begin
                assert (!command_ready)
                    else report_failure("command ready was high while a command was running");
            end
            if (ready_due) begin
                assert (command_ready)
                    else report_failure("command ready did not return after the final idle");
                ready_due <= 1'b0;
            end
            if (spi_ce_4x) begin
                // a clear has only the escape phase, a line write adds the text phase
                if (command_ready && (cmd_clear || cmd_line1 || cmd_line2)) begin
                    cmd_busy    <= 1'b1;
                    phases_left <= cmd_clear ? 1 : 2;
                end
                if (spi_req.go_stand) begin
                    waiting_idle <= 1'b1;
                    phases_left  <= phases_left - 1;
                end else if (waiting_idle && spi_status.spi_idle) begin
                    waiting_idle <= 1'b0;
                    if (phases_left == 0) begin
                        cmd_busy  <= 1'b0;
                        ready_due <= 1'b1;
                    end
                end
            end
        end
    end

    // --------------------
    // expected bytes
    // --------------------
    function automatic void push_byte(input logic [7:0] data, input logic last,
                                      input logic [4:0] len);
        exp_q.push_back('{data: data, go: last, len: len});
    endfunction

    // ESC [ 0 j for a clear, otherwise ESC [ row ; 0 0 H and the 16 text characters
    function automatic void expect_message(input logic clr, input logic l1,
                                           input logic [127:0] t1, input logic [127:0] t2);
        logic [127:0] text;
        logic [7:0]   row;
        if (clr) begin
            push_byte(8'h1B, 1'b0, 5'd4);
            push_byte(8'h5B, 1'b0, 5'd4);
            push_byte(8'h30, 1'b0, 5'd4);
            push_byte(8'h6A, 1'b1, 5'd4);
        end else begin
            row  = l1 ? 8'h30 : 8'h31;
            text = l1 ? t1 : t2;
            push_byte(8'h1B, 1'b0, 5'd7);
            push_byte(8'h5B, 1'b0, 5'd7);
            push_byte(row,   1'b0, 5'd7);
            push_byte(8'h3B, 1'b0, 5'd7);
            push_byte(8'h30, 1'b0, 5'd7);
            push_byte(8'h30, 1'b0, 5'd7);
            push_byte(8'h48, 1'b1, 5'd7);
            // first character sits in the top byte
            for (int i = 15; i >= 0; i--) begin
                push_byte(text[8*i +: 8], (i == 0), 5'd16);
            end
        end
    endfunction

    function automatic logic [127:0] random_line();
        return {$urandom, $urandom, $urandom, $urandom};
    endfunction

    // --------------------
    // stimulus
    // --------------------
    task automatic wait_ready(input int limit, input string what);
        int n;
        n = 0;
        do begin
            @(posedge ext_spi_clk_x);
            n++;
        end while (!command_ready && n < limit);
        assert (command_ready) else report_failure({"timed out waiting for ", what});
    endtask

    task automatic run_command(input logic clr, input logic l1, input logic l2);
        logic [127:0] text1;
        logic [127:0] text2;
        logic         taken;
        int           n;
        text1 = random_line();
        text2 = random_line();
        wait_ready(CMD_LIMIT, "command ready before a command");
        expect_message(clr, l1, text1, text2);
        cmd_clear <= clr;
        cmd_line1 <= l1;
        cmd_line2 <= l2;
        line1     <= text1;
        line2     <= text2;
        // the command is taken on the first enabled edge that sees ready
        taken = 1'b0;
        n     = 0;
        while (!taken && n < CMD_LIMIT) begin
            @(posedge ext_spi_clk_x);
            taken = spi_ce_4x && command_ready;
            n++;
        end
        assert (taken) else report_failure("the command was never accepted");
        // new text right away shows that the old text was captured
        cmd_clear <= 1'b0;
        cmd_line1 <= 1'b0;
        cmd_line2 <= 1'b0;
        line1     <= random_line();
        line2     <= random_line();
        wait_ready(CMD_LIMIT, "the end of a command");
        assert (exp_q.size() == 0)
            else report_failure("the command ended with expected bytes still missing");
    endtask

    initial begin : stimulus
        int sel;
        void'($urandom(32'h110f173b));
        wait_ready(BOOT_LIMIT, "the end of the boot wait");
        run_command(1'b1, 1'b0, 1'b0);
        run_command(1'b0, 1'b1, 1'b0);
        run_command(1'b0, 1'b0, 1'b1);
        // priority cases, clear first and then line 1 over line 2
        run_command(1'b1, 1'b1, 1'b1);
        run_command(1'b0, 1'b1, 1'b1);
        for (int k = 0; k < 8; k++) begin
            sel = int'($urandom_range(7, 1));
            run_command(sel[0], sel[1], sel[2]);
        end
        if (booted && exp_q.size() == 0) begin
            $display("TESTS PASSED");
            $finish;
        end else begin
            report_failure("the run ended with the boot check or scoreboard incomplete");
        end
    end

endmodule
